/* source/hwpe_source_macros.svh */
// width and depth defines for the hwpe source streamer
// lane count, memory word and address widths
// stream sideband widths, counter width, output buffer depth

`ifndef HWPE_SOURCE_MACROS_SVH
`define HWPE_SOURCE_MACROS_SVH

// memory lanes read per request
`define HWPE_NPX 4

// memory side
`define HWPE_WORD_W 32
`define HWPE_ADDR_W 32

// stream sideband
`define HWPE_TID_W   4
`define HWPE_TDEST_W 4
`define HWPE_TUSER_W 8

// line and column counters
`define HWPE_CNT_W 12

// output buffer entries
`define HWPE_BUF_DEPTH 2

`endif

/* source/hwpe_tcdm_pkg.sv */
// memory side types of the hwpe source streamer
// byte address, data word and their per-lane arrays

`default_nettype none

`include "hwpe_source_macros.svh"

package hwpe_tcdm_pkg;

  // one byte address
  typedef logic [`HWPE_ADDR_W-1:0] tcdm_addr_t;

  // one memory word
  typedef logic [`HWPE_WORD_W-1:0] tcdm_word_t;

  // one entry per lane, lane 0 in the low bits
  typedef tcdm_addr_t [`HWPE_NPX-1:0] tcdm_addr_lanes_t;
  typedef tcdm_word_t [`HWPE_NPX-1:0] tcdm_data_lanes_t;

endpackage

`default_nettype wire

/* source/hwpe_source_pkg.sv */
// sequencing types of the hwpe source streamer
// controller state enum and line/column count type

`default_nettype none

`include "hwpe_source_macros.svh"

package hwpe_source_pkg;

  // controller states
  // drain waits for the output buffer after the final grant
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SOURCE = 2'd1,
    DRAIN  = 2'd2
  } source_state_e;

  // a line or column count
  typedef logic [`HWPE_CNT_W-1:0] source_cnt_t;

endpackage

`default_nettype wire

/* source/hwpe_source_addressgen.sv */
// address generator of the hwpe source streamer
// column and line counters with a running line base
// combinational lane addresses, in-progress level, last column and last request

`default_nettype none

`include "hwpe_source_macros.svh"

module hwpe_source_addressgen
  import hwpe_tcdm_pkg::*;
  import hwpe_source_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  logic             adv_i,
  input  tcdm_addr_t       cfg_base_i,
  input  source_cnt_t      cfg_n_lines_i,
  input  source_cnt_t      cfg_n_cols_i,
  input  tcdm_addr_t       cfg_line_stride_i,
  output tcdm_addr_lanes_t addr_o,
  output logic             in_progress_o,
  output logic             last_col_o,
  output logic             last_req_o
);

  source_cnt_t col_q;
  source_cnt_t line_q;
  tcdm_addr_t  line_base_q;
  logic        in_progress_q;
  logic        last_line;
  tcdm_addr_t  col_word;

  // end of line and end of block
  assign last_col_o  = (col_q == cfg_n_cols_i - 1'b1);
  assign last_line   = (line_q == cfg_n_lines_i - 1'b1);
  assign last_req_o  = last_col_o & last_line;

  assign in_progress_o = in_progress_q;

  // counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q         <= '0;
      line_q        <= '0;
      line_base_q   <= '0;
      in_progress_q <= 1'b0;
    end else if (start_i) begin
      // new job, restart at the block origin
      col_q         <= '0;
      line_q        <= '0;
      line_base_q   <= cfg_base_i;
      in_progress_q <= 1'b1;
    end else if (adv_i) begin
      if (last_col_o) begin
        // wrap into the next line
        col_q       <= '0;
        line_q      <= line_q + 1'b1;
        line_base_q <= line_base_q + cfg_line_stride_i;
        // nothing left once the final line wraps
        if (last_line) begin
          in_progress_q <= 1'b0;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // first word index of the current column
  assign col_word = tcdm_addr_t'(col_q) * tcdm_addr_t'(`HWPE_NPX);

  // lane p reads word col*npx+p of the line, 4 bytes per word
  always_comb begin
    for (int p = 0; p < `HWPE_NPX; p++) begin
      addr_o[p] = line_base_q + ((col_word + tcdm_addr_t'(p)) << 2);
    end
  end

  // the controller only steps the walk while a job is open
  a_adv_in_progress : assert property (
    @(posedge clk) disable iff (!rst_n)
    adv_i |-> in_progress_o
  );

endmodule

`default_nettype wire

/* source/hwpe_source_ctrl.sv */
// controller of the hwpe source streamer
// idle/source/drain fsm, lane requests, address advance
// last flag for the output buffer, line-change pulse, done pulse

`default_nettype none

`include "hwpe_source_macros.svh"

module hwpe_source_ctrl
  import hwpe_source_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic [`HWPE_NPX-1:0] tcdm_gnt_i,
  input  logic                 in_progress_i,
  input  logic                 last_col_i,
  input  logic                 last_req_i,
  input  logic                 space_ok_i,
  input  logic                 empty_i,
  output logic                 ready_o,
  output logic                 gen_start_o,
  output logic [`HWPE_NPX-1:0] tcdm_req_o,
  output logic                 adv_o,
  output logic                 push_last_o,
  output logic                 change_feat_o,
  output logic                 done_o
);

  source_state_e state_q;
  source_state_e state_d;
  logic          req_all;
  logic          fire;

  assign ready_o     = (state_q == IDLE);
  assign gen_start_o = ready_o & start_i;

  // all lanes request together while the buffer has room
  // space_ok cannot fall while a request waits, so req holds until granted
  assign req_all    = (state_q == SOURCE) & in_progress_i & space_ok_i;
  assign tcdm_req_o = {`HWPE_NPX{req_all}};

  // full grant, every lane in the same cycle
  assign fire = req_all & (&tcdm_gnt_i);

  assign adv_o         = fire;
  assign change_feat_o = fire & last_col_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = SOURCE;
        end
      end
      SOURCE: begin
        if (fire && last_req_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // empty also covers the read still in flight
        if (empty_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      push_last_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      state_q     <= state_d;
      // lines up with the read data one cycle after the grant
      push_last_o <= fire & last_req_i;
      done_o      <= (state_q == DRAIN) & empty_i;
    end
  end

  // raised requests stay up until the memory grants all lanes
  a_req_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (|tcdm_req_o && !(&tcdm_gnt_i)) |=> (&tcdm_req_o)
  );

endmodule

`default_nettype wire

/* source/hwpe_source_stream_out.sv */
// stream output stage of the hwpe source streamer
// 2-entry circular buffer of lane data plus last flag
// in-flight tracking for free space, emptiness to the controller

`default_nettype none

`include "hwpe_source_macros.svh"

module hwpe_source_stream_out
  import hwpe_tcdm_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rvalid_i,
  input  tcdm_data_lanes_t rdata_i,
  input  logic             last_i,
  input  logic             req_fire_i,
  input  logic             tready_i,
  output logic             tvalid_o,
  output tcdm_data_lanes_t tdata_o,
  output logic             tlast_o,
  output logic             space_ok_o,
  output logic             empty_o
);

  localparam int unsigned ptr_w = $clog2(`HWPE_BUF_DEPTH);
  localparam int unsigned cnt_w = $clog2(`HWPE_BUF_DEPTH + 1);

  tcdm_data_lanes_t   data_mem [`HWPE_BUF_DEPTH];
  logic               last_mem [`HWPE_BUF_DEPTH];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  logic [cnt_w-1:0]   count_q;
  logic               inflight_q;
  logic [cnt_w:0]     occupancy;
  logic               push;
  logic               pop;

  assign push = rvalid_i;
  assign pop  = tvalid_o & tready_i;

  // head of the buffer
  assign tvalid_o = (count_q != '0);
  assign tdata_o  = data_mem[rd_ptr_q];
  assign tlast_o  = tvalid_o & last_mem[rd_ptr_q];

  // stored words plus the one the memory still owes
  assign occupancy  = {1'b0, count_q} + {{cnt_w{1'b0}}, inflight_q};
  assign space_ok_o = (occupancy < (cnt_w + 1)'(`HWPE_BUF_DEPTH));
  assign empty_o    = (occupancy == '0);

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr_q] <= rdata_i;
      last_mem[wr_ptr_q] <= last_i;
    end
  end

  // pointers, count and in-flight flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      inflight_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`HWPE_BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`HWPE_BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // a new grant wins over the return of the previous one
      if (req_fire_i) begin
        inflight_q <= 1'b1;
      end else if (rvalid_i) begin
        inflight_q <= 1'b0;
      end
    end
  end

  // controller gating must keep returning data from hitting a full buffer
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (count_q < cnt_w'(`HWPE_BUF_DEPTH))
  );

endmodule

`default_nettype wire

/* source/hwpe_source.sv */
// top level of the hwpe source streamer
// address generator, controller and stream output stage
// sideband registers sampled at job start

`default_nettype none

`include "hwpe_source_macros.svh"

module hwpe_source
  import hwpe_tcdm_pkg::*;
  import hwpe_source_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // job configuration, stable from start to done
  input  tcdm_addr_t               cfg_base_i,
  input  source_cnt_t              cfg_n_lines_i,
  input  source_cnt_t              cfg_n_cols_i,
  input  tcdm_addr_t               cfg_line_stride_i,
  input  logic [`HWPE_TID_W-1:0]   cfg_tid_i,
  input  logic [`HWPE_TDEST_W-1:0] cfg_tdest_i,
  input  logic [`HWPE_TUSER_W-1:0] cfg_tuser_i,
  // start and done
  input  logic                     start_i,
  output logic                     ready_o,
  output logic                     done_o,
  // memory lanes
  output logic [`HWPE_NPX-1:0]     tcdm_req_o,
  input  logic [`HWPE_NPX-1:0]     tcdm_gnt_i,
  output tcdm_addr_lanes_t         tcdm_add_o,
  input  tcdm_data_lanes_t         tcdm_r_data_i,
  input  logic                     tcdm_r_valid_i,
  // stream output
  output logic                     tvalid_o,
  input  logic                     tready_i,
  output tcdm_data_lanes_t         tdata_o,
  output logic                     tlast_o,
  output logic [`HWPE_TID_W-1:0]   tid_o,
  output logic [`HWPE_TDEST_W-1:0] tdest_o,
  output logic [`HWPE_TUSER_W-1:0] tuser_o,
  output logic                     change_feat_o
);

  logic gen_start;
  logic adv;
  logic in_progress;
  logic last_col;
  logic last_req;
  logic push_last;
  logic space_ok;
  logic empty;

  hwpe_source_addressgen i_addressgen (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .start_i           ( gen_start         ),
    .adv_i             ( adv               ),
    .cfg_base_i        ( cfg_base_i        ),
    .cfg_n_lines_i     ( cfg_n_lines_i     ),
    .cfg_n_cols_i      ( cfg_n_cols_i      ),
    .cfg_line_stride_i ( cfg_line_stride_i ),
    .addr_o            ( tcdm_add_o        ),
    .in_progress_o     ( in_progress       ),
    .last_col_o        ( last_col          ),
    .last_req_o        ( last_req          )
  );

  hwpe_source_ctrl i_ctrl (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .start_i       ( start_i       ),
    .tcdm_gnt_i    ( tcdm_gnt_i    ),
    .in_progress_i ( in_progress   ),
    .last_col_i    ( last_col      ),
    .last_req_i    ( last_req      ),
    .space_ok_i    ( space_ok      ),
    .empty_i       ( empty         ),
    .ready_o       ( ready_o       ),
    .gen_start_o   ( gen_start     ),
    .tcdm_req_o    ( tcdm_req_o    ),
    .adv_o         ( adv           ),
    .push_last_o   ( push_last     ),
    .change_feat_o ( change_feat_o ),
    .done_o        ( done_o        )
  );

  // adv is the full grant, so it marks a read in flight
  hwpe_source_stream_out i_stream_out (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .rvalid_i   ( tcdm_r_valid_i ),
    .rdata_i    ( tcdm_r_data_i  ),
    .last_i     ( push_last      ),
    .req_fire_i ( adv            ),
    .tready_i   ( tready_i       ),
    .tvalid_o   ( tvalid_o       ),
    .tdata_o    ( tdata_o        ),
    .tlast_o    ( tlast_o        ),
    .space_ok_o ( space_ok       ),
    .empty_o    ( empty          )
  );

  // sideband held for the whole job
  always_ff @(posedge clk) begin
    if (gen_start) begin
      tid_o   <= cfg_tid_i;
      tdest_o <= cfg_tdest_i;
      tuser_o <= cfg_tuser_i;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_hwpe_source.sv */
// testbench for the hwpe source streamer
// clock, reset, lane memory model with random grants and ready
// jobs read from the cases file, address, data, last and sideband checks

`default_nettype none

`include "hwpe_source_macros.svh"

module tb_hwpe_source
  import hwpe_tcdm_pkg::*;
  import hwpe_source_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_cases = 14;
  localparam int case_words = 9;
  localparam logic [31:0] data_pattern = 32'h5a5a_0000;

  logic                     clk;
  logic                     rst_n;
  tcdm_addr_t               cfg_base_i;
  source_cnt_t              cfg_n_lines_i;
  source_cnt_t              cfg_n_cols_i;
  tcdm_addr_t               cfg_line_stride_i;
  logic [`HWPE_TID_W-1:0]   cfg_tid_i;
  logic [`HWPE_TDEST_W-1:0] cfg_tdest_i;
  logic [`HWPE_TUSER_W-1:0] cfg_tuser_i;
  logic                     start_i;
  logic                     ready_o;
  logic                     done_o;
  logic [`HWPE_NPX-1:0]     tcdm_req_o;
  logic [`HWPE_NPX-1:0]     tcdm_gnt_i;
  tcdm_addr_lanes_t         tcdm_add_o;
  tcdm_data_lanes_t         tcdm_r_data_i;
  logic                     tcdm_r_valid_i;
  logic                     tvalid_o;
  logic                     tready_i;
  tcdm_data_lanes_t         tdata_o;
  logic                     tlast_o;
  logic [`HWPE_TID_W-1:0]   tid_o;
  logic [`HWPE_TDEST_W-1:0] tdest_o;
  logic [`HWPE_TUSER_W-1:0] tuser_o;
  logic                     change_feat_o;

  // one job per 9 words
  logic [31:0] case_mem [0:n_cases*case_words-1];

  logic [3:0]       gnt_prob;
  logic [3:0]       rdy_prob;
  logic [31:0]      rng;
  string            case_name = "reset";
  int               errors = 0;
  int               checks = 0;
  logic             timed_out = 1'b0;

  // monitor state
  logic             full_grant = 1'b0;
  logic             rsp_pending = 1'b0;
  tcdm_addr_lanes_t rsp_addr = '0;
  logic             job_active = 1'b0;
  logic             req_waiting = 1'b0;
  int               grant_line = 0;
  int               grant_col = 0;
  int               xfer_line = 0;
  int               xfer_col = 0;
  int               xfer_count = 0;
  int               feat_count = 0;
  int               done_count = 0;

  // port names match the DUT one to one
  hwpe_source i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // lane p of column c in line l
  function automatic tcdm_addr_t lane_address(input int l, input int c, input int p);
    return cfg_base_i + tcdm_addr_t'(l) * cfg_line_stride_i
           + tcdm_addr_t'((c * `HWPE_NPX + p) * 4);
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", case_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_condition(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error in %s: %s", case_name, what);
      errors++;
    end
  endtask

  // memory lanes and stream sink, driven 10 ns after the edge
  initial begin
    tcdm_gnt_i     = '0;
    tcdm_r_valid_i = 1'b0;
    tcdm_r_data_i  = '0;
    tready_i       = 1'b0;
    rng            = 32'hbec9;
    forever begin
      @(posedge clk);
      #10;
      for (int p = 0; p < `HWPE_NPX; p++) begin
        rng = next_random(rng);
        tcdm_gnt_i[p] = (rng[3:0] <= gnt_prob);
      end
      rng = next_random(rng);
      tready_i = (rng[3:0] <= rdy_prob);
      // read data one cycle after the full grant
      tcdm_r_valid_i = rsp_pending;
      for (int p = 0; p < `HWPE_NPX; p++) begin
        tcdm_r_data_i[p] = rsp_pending ? (rsp_addr[p] ^ data_pattern) : '0;
      end
    end
  end

  // sampled mid-cycle, all inputs settled
  always @(negedge clk) begin
    if (rst_n) begin
      full_grant  = (&tcdm_req_o) && (&tcdm_gnt_i);
      rsp_pending = full_grant;
      rsp_addr    = tcdm_add_o;
      if (ready_o && start_i) begin
        job_active  = 1'b1;
        req_waiting = 1'b0;
        grant_line  = 0;
        grant_col   = 0;
        xfer_line   = 0;
        xfer_col    = 0;
        xfer_count  = 0;
        feat_count  = 0;
        done_count  = 0;
      end
      check_condition("lane requests not raised together",
                      (tcdm_req_o == '0) || (&tcdm_req_o));
      if (req_waiting) begin
        check_condition("request dropped before its full grant", &tcdm_req_o);
      end
      // address stays put until the walk advances on a full grant
      if (|tcdm_req_o) begin
        for (int p = 0; p < `HWPE_NPX; p++) begin
          check_value($sformatf("address lane %0d", p),
                      lane_address(grant_line, grant_col, p), tcdm_add_o[p]);
        end
      end
      req_waiting = (|tcdm_req_o) && !full_grant;
      check_value("change_feat", full_grant && (grant_col == int'(cfg_n_cols_i) - 1),
                  change_feat_o);
      if (change_feat_o) begin
        feat_count++;
      end
      if (full_grant) begin
        if (grant_col == int'(cfg_n_cols_i) - 1) begin
          grant_col = 0;
          grant_line++;
        end else begin
          grant_col++;
        end
      end
      // transfer, line then column order
      if (tvalid_o && tready_i) begin
        check_condition("word beyond the end of the job",
                        xfer_count < int'(cfg_n_lines_i) * int'(cfg_n_cols_i));
        for (int p = 0; p < `HWPE_NPX; p++) begin
          check_value($sformatf("data lane %0d", p),
                      lane_address(xfer_line, xfer_col, p) ^ data_pattern, tdata_o[p]);
        end
        check_value("tlast", (xfer_line == int'(cfg_n_lines_i) - 1)
                    && (xfer_col == int'(cfg_n_cols_i) - 1), tlast_o);
        check_value("tid", cfg_tid_i, tid_o);
        check_value("tdest", cfg_tdest_i, tdest_o);
        check_value("tuser", cfg_tuser_i, tuser_o);
        xfer_count++;
        if (xfer_col == int'(cfg_n_cols_i) - 1) begin
          xfer_col = 0;
          xfer_line++;
        end else begin
          xfer_col++;
        end
      end
      if (done_o) begin
        check_condition("done pulse outside a job or before the last word",
                        job_active && (xfer_count == int'(cfg_n_lines_i) * int'(cfg_n_cols_i)));
        job_active = 1'b0;
        done_count++;
      end
    end
  end

  task automatic run_job(input int k);
    int idx;
    int cycles;
    int limit;
    idx = k * case_words;
    @(posedge clk);
    #10;
    case_name         = $sformatf("case%0d", k);
    cfg_base_i        = case_mem[idx];
    cfg_n_lines_i     = source_cnt_t'(case_mem[idx+1]);
    cfg_n_cols_i      = source_cnt_t'(case_mem[idx+2]);
    cfg_line_stride_i = case_mem[idx+3];
    cfg_tid_i         = case_mem[idx+4][`HWPE_TID_W-1:0];
    cfg_tdest_i       = case_mem[idx+5][`HWPE_TDEST_W-1:0];
    cfg_tuser_i       = case_mem[idx+6][`HWPE_TUSER_W-1:0];
    gnt_prob          = case_mem[idx+7][3:0];
    rdy_prob          = case_mem[idx+8][3:0];
    start_i           = 1'b1;
    @(negedge clk);
    check_value("ready at start", 1'b1, ready_o);
    @(posedge clk);
    #10;
    start_i = 1'b0;
    @(negedge clk);
    check_value("ready after start", 1'b0, ready_o);
    // generous bound, low ready and grant rates stretch a job
    limit  = 200 + 400 * int'(cfg_n_lines_i) * int'(cfg_n_cols_i);
    cycles = 0;
    while (!done_o && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done_o) begin
      $display("Timeout in %s: no done pulse after %0d cycles", case_name, cycles);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_value("ready with done", 1'b1, ready_o);
      @(posedge clk);
      #10;
      check_value("word count", int'(cfg_n_lines_i) * int'(cfg_n_cols_i), xfer_count);
      check_value("change_feat count", cfg_n_lines_i, feat_count);
      check_value("done count", 1, done_count);
      check_value("ready after done", 1'b1, ready_o);
    end
  endtask

  initial begin
    rst_n             = 1'b0;
    start_i           = 1'b0;
    cfg_base_i        = '0;
    cfg_n_lines_i     = '0;
    cfg_n_cols_i      = '0;
    cfg_line_stride_i = '0;
    cfg_tid_i         = '0;
    cfg_tdest_i       = '0;
    cfg_tuser_i       = '0;
    gnt_prob          = 4'hf;
    rdy_prob          = 4'hf;
    $readmemh("bench/source_cases.txt", case_mem);
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ready after reset", 1'b1, ready_o);
    check_value("req after reset", '0, tcdm_req_o);
    check_value("tvalid after reset", 1'b0, tvalid_o);
    check_value("done after reset", 1'b0, done_o);
    check_value("change_feat after reset", 1'b0, change_feat_o);
    for (int k = 0; k < n_cases && !timed_out; k++) begin
      run_job(k);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hwpe_source.f */
+incdir+source
source/hwpe_tcdm_pkg.sv
source/hwpe_source_pkg.sv
source/hwpe_source_addressgen.sv
source/hwpe_source_ctrl.sv
source/hwpe_source_stream_out.sv
source/hwpe_source.sv
bench/tb_hwpe_source.sv

/* bench/source_cases.txt */
// base lines cols stride tid tdest tuser gnt_prob rdy_prob, all hex
// probabilities are nibbles, a draw at or below the nibble means high
00001000 001 001 00000040 1 2 11 f f
00002000 002 003 00000100 3 4 a5 f f
00004000 004 004 00000080 5 6 3c c f
00008010 003 008 00000200 7 8 ff f 2
0000a000 005 002 00000020 9 a 01 d 1
00010000 001 010 00001000 b c 5a b 8
00020004 006 003 00000040 d e 77 e 3
00030000 002 005 00000400 f 0 80 a e
00000000 003 001 00000010 2 3 c3 f 0
0fff0000 004 006 00000100 4 5 2e b 7
00040100 002 002 00010000 6 7 99 9 f
00050000 005 004 000000c0 8 9 42 e 1
00060000 001 006 00000000 a b d4 c 5
7fff0000 003 003 00000030 c d 6b f 4
